// File: lpif_pkg.sv
// LPIF link shared types
`default_nettype none

package lpif_pkg;

  ////////////////////
  // Widths

  // User flit data field
  localparam int data_w = 64;
  // One PHY lane word
  localparam int lane_w = 44;
  // Payload bits carried per lane, two lanes hold flit plus one pad bit
  localparam int lane_payload_w = 41;
  // Lane marker user bits
  localparam int marker_w = 2;
  // Debug status word
  localparam int dbg_w = 32;

  ////////////////////
  // Flit and lane formats

  // Downstream / upstream flit, 81 bits
  typedef struct packed {
    logic [3:0]        state;
    logic [1:0]        protid;
    logic [data_w-1:0] data;
    logic              dvalid;
    logic [7:0]        crc;
    logic              crc_valid;
    logic              valid;
  } lpif_flit_t;

  // One PHY lane word, strobe on top
  typedef struct packed {
    logic                      strobe;
    logic [marker_w-1:0]       marker;
    logic [lane_payload_w-1:0] payload;
  } lane_word_t;

  // Debug status bit positions
  localparam int dbg_tx_online_bit = 19;
  localparam int dbg_rx_online_bit = 18;
  localparam int dbg_lane_err_bit  = 0;

endpackage

`default_nettype wire

// File: ll_auto_sync.sv
// Link online sequencing
`default_nettype none

module ll_auto_sync (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [1:0]  tx_mrk_userbit,
  input  logic        tx_stb_userbit,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic [1:0]  tx_auto_mrk_userbit,
  output logic        tx_auto_stb_userbit
);

  // Cycles spent with each enable high
  logic [15:0] tx_cnt;
  logic [15:0] rx_cnt;
  // Receive side waits for transmit to be online
  logic        rx_enable;

  // Count up, stick at all ones
  function automatic logic [15:0] sat_inc(input logic [15:0] cnt);
    sat_inc = (cnt == 16'hffff) ? cnt : cnt + 16'd1;
  endfunction

  assign rx_enable = rx_online && tx_online_delay;

  ////////////////////
  // Transmit delay

  // Counter restarts whenever tx_online drops
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else if (!tx_online) begin
      tx_cnt          <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      tx_cnt          <= sat_inc(tx_cnt);
      // Edge that samples count == delay_x raises the output
      tx_online_delay <= tx_online_delay || (tx_cnt >= delay_x_value);
    end
  end

  ////////////////////
  // Receive delay

  // Same scheme, counted from rx_online with transmit already up
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_enable) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      rx_cnt          <= sat_inc(rx_cnt);
      rx_online_delay <= rx_online_delay || (rx_cnt >= delay_y_value);
    end
  end

  ////////////////////
  // Lane user bits

  // Persistent marker and strobe while transmitting
  assign tx_auto_mrk_userbit = tx_online_delay ? tx_mrk_userbit : 2'b00;
  assign tx_auto_stb_userbit = tx_online_delay ? tx_stb_userbit : 1'b0;

endmodule

`default_nettype wire

// File: lpif_user_pack.sv
// LPIF user side registers
`default_nettype none

module lpif_user_pack #(
  parameter int DATA_W = 64
) (
  input  logic                 clk_wr,
  input  logic                 reset,
  input  lpif_pkg::lpif_flit_t dstrm,
  input  lpif_pkg::lpif_flit_t rx_flit,
  input  logic                 rx_online_delay,
  output lpif_pkg::lpif_flit_t tx_flit,
  output lpif_pkg::lpif_flit_t ustrm
);

  ////////////////////
  // Downstream

  // One cycle from the user ports into the flit
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      // Only the strobe matters after reset
      tx_flit.valid <= 1'b0;
    end else begin
      tx_flit.state     <= dstrm.state;
      tx_flit.protid    <= dstrm.protid;
      tx_flit.data      <= dstrm.data[DATA_W-1:0];
      tx_flit.dvalid    <= dstrm.dvalid;
      tx_flit.crc       <= dstrm.crc;
      tx_flit.crc_valid <= dstrm.crc_valid;
      // Idle cycles pass through with valid low
      tx_flit.valid     <= dstrm.valid;
    end
  end

  ////////////////////
  // Upstream

  // Reassembled flit out to the user, one cycle
  // Offline receive gives all zeros so no stale lane data leaks out
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm <= '0;
    end else if (!rx_online_delay) begin
      ustrm <= '0;
    end else begin
      ustrm <= rx_flit;
    end
  end

endmodule

`default_nettype wire

// File: lpif_lane_concat.sv
// Flit to PHY lane split and merge
`default_nettype none

module lpif_lane_concat #(
  parameter int DATA_W = 64,
  parameter int LANE_W = 44
) (
  input  logic                 clk_wr,
  input  logic                 reset,
  input  lpif_pkg::lpif_flit_t tx_flit,
  input  logic                 tx_online_delay,
  input  logic [1:0]           tx_mrk_userbit,
  input  logic                 tx_stb_userbit,
  input  logic [LANE_W-1:0]    rx_phy0,
  input  logic [LANE_W-1:0]    rx_phy1,
  output logic [LANE_W-1:0]    tx_phy0,
  output logic [LANE_W-1:0]    tx_phy1,
  output lpif_pkg::lpif_flit_t rx_flit,
  output logic                 lane_err
);

  // Lane word minus strobe and marker
  localparam int payload_w = LANE_W - 3;
  // Flit is data plus 17 bits of side fields
  localparam int flit_w    = DATA_W + 17;
  // Zero fill on top of the flit
  localparam int pad_w     = 2 * payload_w - flit_w;

  logic [2*payload_w-1:0] tx_wide;
  lpif_pkg::lane_word_t   tx_lane0_d;
  lpif_pkg::lane_word_t   tx_lane1_d;
  lpif_pkg::lane_word_t   tx_lane0_q;
  lpif_pkg::lane_word_t   tx_lane1_q;

  lpif_pkg::lane_word_t   rx_lane0;
  lpif_pkg::lane_word_t   rx_lane1;
  logic [2*payload_w-1:0] rx_wide;
  lpif_pkg::lpif_flit_t   rx_flit_d;

  ////////////////////
  // Transmit split

  // Pad bit sits above the flit MSB
  assign tx_wide = {{pad_w{1'b0}}, tx_flit};

  // Low half on lane 0, high half on lane 1, same user bits on both
  always_comb begin
    tx_lane0_d.strobe  = tx_stb_userbit;
    tx_lane0_d.marker  = tx_mrk_userbit;
    tx_lane0_d.payload = tx_wide[payload_w-1:0];
    tx_lane1_d.strobe  = tx_stb_userbit;
    tx_lane1_d.marker  = tx_mrk_userbit;
    tx_lane1_d.payload = tx_wide[2*payload_w-1:payload_w];
  end

  always_ff @(posedge clk_wr) begin
    tx_lane0_q <= tx_lane0_d;
    tx_lane1_q <= tx_lane1_d;
  end

  // Lanes silent until transmit is online
  assign tx_phy0 = tx_online_delay ? tx_lane0_q : '0;
  assign tx_phy1 = tx_online_delay ? tx_lane1_q : '0;

  ////////////////////
  // Receive merge

  assign rx_lane0 = rx_phy0;
  assign rx_lane1 = rx_phy1;

  // Join the halves, top pad bit dropped
  assign rx_wide   = {rx_lane1.payload, rx_lane0.payload};
  assign rx_flit_d = rx_wide[flit_w-1:0];

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_flit.valid <= 1'b0;
    end else begin
      rx_flit <= rx_flit_d;
    end
  end

  // Sticky lane misalignment, both lanes strobed with different markers
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      lane_err <= 1'b0;
    end else if (rx_lane0.strobe && rx_lane1.strobe &&
                 (rx_lane0.marker != rx_lane1.marker)) begin
      lane_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: lpif_link_top.sv
// LPIF link master top level
`default_nettype none

module lpif_link_top #(
  parameter int DATA_W = lpif_pkg::data_w,
  parameter int LANE_W = lpif_pkg::lane_w
) (
  input  logic                       clk_wr,
  input  logic                       reset,
  // Control and configuration
  input  logic                       tx_online,
  input  logic                       rx_online,
  input  logic [1:0]                 tx_mrk_userbit,
  input  logic                       tx_stb_userbit,
  input  logic [15:0]                delay_x_value,
  input  logic [15:0]                delay_y_value,
  // User side
  input  lpif_pkg::lpif_flit_t       dstrm,
  output lpif_pkg::lpif_flit_t       ustrm,
  // PHY lanes
  output logic [LANE_W-1:0]          tx_phy0,
  output logic [LANE_W-1:0]          tx_phy1,
  input  logic [LANE_W-1:0]          rx_phy0,
  input  logic [LANE_W-1:0]          rx_phy1,
  // Status
  output logic [lpif_pkg::dbg_w-1:0] debug_status
);

  lpif_pkg::lpif_flit_t       tx_flit;
  lpif_pkg::lpif_flit_t       rx_flit;
  logic                       tx_online_delay;
  logic                       rx_online_delay;
  logic [1:0]                 tx_auto_mrk_userbit;
  logic                       tx_auto_stb_userbit;
  logic                       lane_err;
  logic [lpif_pkg::dbg_w-1:0] debug_next;

  ////////////////////
  // Online sequencing
  ll_auto_sync ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .reset               (reset),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // User registers, FIFO and credits bypassed
  lpif_user_pack #(
    .DATA_W (DATA_W)
  ) lpif_user_pack_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .dstrm           (dstrm),
    .rx_flit         (rx_flit),
    .rx_online_delay (rx_online_delay),
    .tx_flit         (tx_flit),
    .ustrm           (ustrm)
  );

  ////////////////////
  // PHY side
  lpif_lane_concat #(
    .DATA_W (DATA_W),
    .LANE_W (LANE_W)
  ) lpif_lane_concat_i (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_flit         (tx_flit),
    .tx_online_delay (tx_online_delay),
    .tx_mrk_userbit  (tx_auto_mrk_userbit),
    .tx_stb_userbit  (tx_auto_stb_userbit),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_flit         (rx_flit),
    .lane_err        (lane_err)
  );

  // Status word, unused bits stay zero
  always_comb begin
    debug_next = '0;
    debug_next[lpif_pkg::dbg_tx_online_bit] = tx_online_delay;
    debug_next[lpif_pkg::dbg_rx_online_bit] = rx_online_delay;
    debug_next[lpif_pkg::dbg_lane_err_bit]  = lane_err;
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      debug_status <= '0;
    end else begin
      debug_status <= debug_next;
    end
  end

endmodule

`default_nettype wire

// File: lpif_link_assert.sv
// LPIF link protocol assertions
`default_nettype none

module lpif_link_assert (
  input logic                        clk_wr,
  input logic                        reset,
  input logic                        ustrm_valid,
  input logic                        tx_online_delay,
  input logic                        rx_online_delay,
  input logic [lpif_pkg::lane_w-1:0] tx_phy0,
  input logic [lpif_pkg::lane_w-1:0] tx_phy1,
  input logic                        lane_err
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far, summed into the run result
  int fail_count = 0;

  // Upstream flit only after receive was online on the previous edge
  ustrm_gated: assert property (@(posedge clk_wr) disable iff (reset)
    ustrm_valid |-> $past(rx_online_delay))
    else begin
      fail_count++;
      $error("ustrm.valid high while rx_online_delay was low");
    end

  // Lanes silent while transmit is offline
  phy_silent: assert property (@(posedge clk_wr) disable iff (reset)
    !tx_online_delay |-> (tx_phy0 == '0) && (tx_phy1 == '0))
    else begin
      fail_count++;
      $error("tx_phy words not zero while tx_online_delay is low");
    end

  // Sticky error, only reset clears it
  err_sticky: assert property (@(posedge clk_wr) disable iff (reset)
    !$past(reset) |-> !$fell(lane_err))
    else begin
      fail_count++;
      $error("lane_err fell outside reset");
    end

endmodule

bind lpif_link_top lpif_link_assert lpif_link_assert_i (
  .clk_wr          (clk_wr),
  .reset           (reset),
  .ustrm_valid     (ustrm.valid),
  .tx_online_delay (tx_online_delay),
  .rx_online_delay (rx_online_delay),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .lane_err        (lane_err)
);

`default_nettype wire

// File: lpif_link_checker.sv
// LPIF link output checker
`default_nettype none

module lpif_link_checker (
  input logic                        clk_wr,
  input logic                        reset,
  // 0 off, 1 lanes only, 2 lanes and loopback, 3 lanes with upstream gated
  input logic [1:0]                  mode,
  input lpif_pkg::lpif_flit_t        dstrm,
  input logic [1:0]                  tx_mrk_userbit,
  input logic                        tx_stb_userbit,
  input logic [lpif_pkg::lane_w-1:0] tx_phy0,
  input logic [lpif_pkg::lane_w-1:0] tx_phy1,
  input lpif_pkg::lpif_flit_t        ustrm
);
  timeunit 1ns;
  timeprecision 1ps;

  int                   err_count = 0;
  // Input history, index is edges ago
  lpif_pkg::lpif_flit_t flit_h [4];
  logic [1:0]           mode_h [4] = '{default: 2'd0};
  logic [1:0]           mrk_now;
  logic                 stb_now;
  lpif_pkg::lane_word_t exp_lane0;
  lpif_pkg::lane_word_t exp_lane1;
  lpif_pkg::lpif_flit_t exp_ustrm;

  // Expected lane word, flit zero padded to 82 bits, lane 0 takes the low half
  function automatic lpif_pkg::lane_word_t lane_ref(input lpif_pkg::lpif_flit_t flit,
                                                    input logic [1:0] mrk, input logic stb,
                                                    input int lane);
    logic [2*lpif_pkg::lane_payload_w-1:0] padded;
    lpif_pkg::lane_word_t                  word;
    padded       = {1'b0, flit};
    word.strobe  = stb;
    word.marker  = mrk;
    word.payload = padded[lane*lpif_pkg::lane_payload_w +: lpif_pkg::lane_payload_w];
    return word;
  endfunction

  task automatic expect_equal(input string name, input logic [95:0] expected,
                              input logic [95:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  ////////////////////
  // Sample inputs

  always @(posedge clk_wr) begin
    for (int i = 3; i > 0; i--) begin
      flit_h[i] <= flit_h[i-1];
      mode_h[i] <= mode_h[i-1];
    end
    flit_h[0] <= dstrm;
    mode_h[0] <= mode;
    // User bits join the flit one edge after it is registered
    mrk_now   <= tx_mrk_userbit;
    stb_now   <= tx_stb_userbit;
  end

  ////////////////////
  // Compare outputs

  always @(negedge clk_wr) begin
    // Lanes two edges after the flit
    if (!reset && mode_h[1] != 2'd0) begin
      exp_lane0 = lane_ref(flit_h[1], mrk_now, stb_now, 0);
      exp_lane1 = lane_ref(flit_h[1], mrk_now, stb_now, 1);
      expect_equal("tx_phy0", 96'(exp_lane0), 96'(tx_phy0));
      expect_equal("tx_phy1", 96'(exp_lane1), 96'(tx_phy1));
    end
    // Upstream four edges after, zero while receive is offline
    if (!reset && mode_h[3] >= 2'd2) begin
      exp_ustrm = (mode_h[3] == 2'd2) ? flit_h[3] : '0;
      expect_equal("ustrm", 96'(exp_ustrm), 96'(ustrm));
    end
  end

endmodule

`default_nettype wire

// File: tb_lpif_link.sv
// LPIF link testbench
`default_nettype none

module tb_lpif_link;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int lane_w = lpif_pkg::lane_w;
  // Both marker bits of a lane word
  localparam logic [lane_w-1:0] marker_flip = {1'b0, 2'b11, 41'd0};
  localparam int wait_limit = 64;

  logic                 clk_wr = 1'b0;
  logic                 reset;
  logic                 tx_online;
  logic                 rx_online;
  logic [1:0]           tx_mrk_userbit;
  logic                 tx_stb_userbit;
  logic [15:0]          delay_x_value;
  logic [15:0]          delay_y_value;
  lpif_pkg::lpif_flit_t dstrm;
  lpif_pkg::lpif_flit_t ustrm;
  logic [lane_w-1:0]    tx_phy0;
  logic [lane_w-1:0]    tx_phy1;
  logic [lane_w-1:0]    rx_phy0;
  logic [lane_w-1:0]    rx_phy1;
  logic [31:0]          debug_status;
  logic [1:0]           check_mode;
  logic                 corrupt;
  bit                   timed_out = 1'b0;
  int                   tests_run = 0;
  int                   tests_failed = 0;
  int                   errs_before;

  always #4 clk_wr = ~clk_wr;

  // PHY loopback with optional lane 1 marker flip
  assign rx_phy0 = tx_phy0;
  assign rx_phy1 = corrupt ? (tx_phy1 ^ marker_flip) : tx_phy1;

  lpif_link_top dut_i (
    .clk_wr (clk_wr), .reset (reset), .tx_online (tx_online), .rx_online (rx_online),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .dstrm (dstrm), .ustrm (ustrm), .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1),
    .rx_phy0 (rx_phy0), .rx_phy1 (rx_phy1), .debug_status (debug_status)
  );

  lpif_link_checker checker_i (
    .clk_wr (clk_wr), .reset (reset), .mode (check_mode), .dstrm (dstrm),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1), .ustrm (ustrm)
  );

  function automatic int total_errors();
    return checker_i.err_count + dut_i.lpif_link_assert_i.fail_count;
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1: return "reset";
      2: return "online sequencing";
      3: return "transmit encoding";
      4: return "loopback";
      5: return "receive gating";
      default: return "lane alignment error";
    endcase
  endfunction

  // Roughly one idle cycle in four
  function automatic lpif_pkg::lpif_flit_t random_flit();
    lpif_pkg::lpif_flit_t f;
    f.state     = 4'($urandom);
    f.protid    = 2'($urandom);
    f.data      = {$urandom, $urandom};
    f.dvalid    = 1'($urandom);
    f.crc       = 8'($urandom);
    f.crc_valid = 1'($urandom);
    f.valid     = ($urandom % 4) != 0;
    return f;
  endfunction

  // Cycles counted in falling edges
  task automatic wait_bit(input int idx, input logic value, output int cycles);
    cycles = 0;
    while (debug_status[idx] !== value && cycles < wait_limit) begin
      @(negedge clk_wr);
      cycles++;
    end
    if (debug_status[idx] !== value) begin
      timed_out = 1'b1;
      $display("Timeout: debug_status bit %0d did not become %0b within %0d cycles",
               idx, value, wait_limit);
    end
  endtask

  task automatic send_flits(input int count, input logic [1:0] mode);
    for (int n = 0; n < count; n++) begin
      @(negedge clk_wr);
      check_mode     = mode;
      dstrm          = random_flit();
      tx_mrk_userbit = 2'($urandom);
      tx_stb_userbit = 1'($urandom);
    end
    @(negedge clk_wr);
    check_mode = 2'd0;
    dstrm      = '0;
    // Drain the four stage path
    repeat (5) @(negedge clk_wr);
  endtask

  ////////////////////
  // Tests

  task automatic reset_values();
    @(negedge clk_wr);
    // Online inputs up while reset holds the sequencer
    tx_online = 1'b1;
    rx_online = 1'b1;
    repeat (9) @(negedge clk_wr);
    reset = 1'b0;
    @(negedge clk_wr);
    checker_i.expect_equal("ustrm", '0, 96'(ustrm));
    checker_i.expect_equal("tx_phy0", '0, 96'(tx_phy0));
    checker_i.expect_equal("tx_phy1", '0, 96'(tx_phy1));
    checker_i.expect_equal("debug_status", '0, 96'(debug_status));
    tx_online = 1'b0;
    rx_online = 1'b0;
  endtask

  task automatic online_sequence();
    int cycles;
    @(negedge clk_wr);
    tx_online = 1'b1;
    wait_bit(lpif_pkg::dbg_tx_online_bit, 1'b1, cycles);
    if (timed_out) return;
    // Sampling edge, then delay cycles, then the status register
    checker_i.expect_equal("tx online rise cycles", 96'(int'(delay_x_value) + 2),
                           96'(cycles));
    rx_online = 1'b1;
    wait_bit(lpif_pkg::dbg_rx_online_bit, 1'b1, cycles);
    if (timed_out) return;
    checker_i.expect_equal("rx online rise cycles", 96'(int'(delay_y_value) + 2),
                           96'(cycles));
    tx_online = 1'b0;
    rx_online = 1'b0;
    wait_bit(lpif_pkg::dbg_tx_online_bit, 1'b0, cycles);
    if (timed_out) return;
    // Both drop on the sampling edge and status one edge later
    checker_i.expect_equal("tx online fall cycles", 96'(2), 96'(cycles));
    checker_i.expect_equal("debug_status rx online", '0,
                           96'(debug_status[lpif_pkg::dbg_rx_online_bit]));
  endtask

  task automatic tx_encoding();
    int cycles;
    @(negedge clk_wr);
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_bit(lpif_pkg::dbg_tx_online_bit, 1'b1, cycles);
    if (timed_out) return;
    wait_bit(lpif_pkg::dbg_rx_online_bit, 1'b1, cycles);
    if (timed_out) return;
    send_flits(200, 2'd1);
  endtask

  task automatic rx_gating();
    int cycles;
    @(negedge clk_wr);
    rx_online = 1'b0;
    wait_bit(lpif_pkg::dbg_rx_online_bit, 1'b0, cycles);
    if (timed_out) return;
    send_flits(100, 2'd3);
  endtask

  task automatic lane_error_sticky();
    int cycles;
    @(negedge clk_wr);
    dstrm          = random_flit();
    tx_mrk_userbit = 2'b01;
    tx_stb_userbit = 1'b1;
    repeat (3) @(negedge clk_wr);
    checker_i.expect_equal("lane error before corrupt", '0,
                           96'(debug_status[lpif_pkg::dbg_lane_err_bit]));
    // One strobed word with lane 1 markers flipped
    corrupt = 1'b1;
    @(negedge clk_wr);
    corrupt = 1'b0;
    wait_bit(lpif_pkg::dbg_lane_err_bit, 1'b1, cycles);
    if (timed_out) return;
    repeat (10) begin
      @(negedge clk_wr);
      checker_i.expect_equal("lane error held", 96'(1),
                             96'(debug_status[lpif_pkg::dbg_lane_err_bit]));
    end
    reset     = 1'b1;
    tx_online = 1'b0;
    repeat (10) @(negedge clk_wr);
    reset = 1'b0;
    @(negedge clk_wr);
    checker_i.expect_equal("debug_status after reset", '0, 96'(debug_status));
  endtask

  ////////////////////
  // Main sequence

  initial begin
    void'($urandom(11));
    reset          = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    tx_mrk_userbit = 2'b00;
    tx_stb_userbit = 1'b0;
    delay_x_value  = 16'd5;
    delay_y_value  = 16'd3;
    dstrm          = '0;
    check_mode     = 2'd0;
    corrupt        = 1'b0;
    for (int t = 1; t <= 6; t++) begin
      if (!timed_out) begin
        errs_before = total_errors();
        case (t)
          1: reset_values();
          2: online_sequence();
          3: tx_encoding();
          4: send_flits(200, 2'd2);
          5: rx_gating();
          default: lane_error_sticky();
        endcase
        tests_run++;
        if (timed_out || total_errors() != errs_before) begin
          tests_failed++;
          $display("Test %0d %s: failed with %0d errors", t, test_name(t),
                   total_errors() - errs_before);
        end else begin
          $display("Test %0d %s: ok", t, test_name(t));
        end
      end
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors());
    if (tests_failed == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
lpif_pkg.sv
ll_auto_sync.sv
lpif_user_pack.sv
lpif_lane_concat.sv
lpif_link_top.sv
lpif_link_assert.sv
lpif_link_checker.sv
tb_lpif_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LPIF link testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lpif_link -f sim.f -o tb_lpif_link
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the summary is printed
./obj_dir/tb_lpif_link +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qF '*** PASSED ***' "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
